/* cpu_core.f */
+incdir+bench
logic/cpu_pkg.sv
logic/dec_exec_if.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/exec_stage.sv
logic/mult_pipe.sv
logic/result_stage.sv
logic/cpu_core.sv
bench/cpu_core_tb.sv

/* Bender.yml */
package:
  name: cpu_core

sources:
  - logic/cpu_pkg.sv
  - logic/dec_exec_if.sv
  - logic/reg_file.sv
  - logic/decode_stage.sv
  - logic/exec_stage.sv
  - logic/mult_pipe.sv
  - logic/result_stage.sv
  - logic/cpu_core.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/cpu_core_tb.sv

/* bench/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

typedef struct packed {
   logic [31:0] cyc;  // Cycle count when the write-back shows
   logic [4:0]  rd;
   logic [31:0] val;
} exp_t;

data_t       model_regs [32];
exp_t        exp_q [$];        // Sorted by completion cycle
logic [31:0] lfsr_state;

// Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] next_random(int nbits);
   logic [31:0] bits;
   logic        fb;
   bits = '0;
   for (int n = 0; n < nbits; n++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      bits       = {bits[30:0], fb};  // One step per bit
   end
   return bits;
endfunction

function automatic data_t rtype_word(logic [5:0] fn, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt);
   return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
endfunction

function automatic data_t itype_word(logic [5:0] op, reg_addr_t rt, reg_addr_t rs, logic [15:0] imm);
   return {op, rs, rt, imm};
endfunction

// Applies one instruction to the model and queues its write-back
function automatic void predict(data_t word, int issued);
   data_t     a;
   data_t     b;
   data_t     res;
   reg_addr_t dst;
   int        lat;
   logic      ok;
   exp_t      e;
   int        pos;
   a   = model_regs[word[25:21]];
   b   = model_regs[word[20:16]];
   dst = word[20:16];  // I-type writes rt
   lat = 2;
   ok  = 1'b1;
   res = '0;
   case (word[31:26])
      OP_RTYPE: begin
         dst = word[15:11];
         case (word[5:0])
            FN_ADD:  res = a + b;
            FN_SUB:  res = a - b;
            FN_AND:  res = a & b;
            FN_OR:   res = a | b;
            FN_XOR:  res = a ^ b;
            FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            FN_MULT: begin
               res = a * b;  // Low word of the product
               lat = MULT_STAGES + 1;
            end
            default: ok = 1'b0;
         endcase
      end
      OP_ADDI: res = a + {{16{word[15]}}, word[15:0]};
      OP_ANDI: res = a & {16'h0000, word[15:0]};
      OP_ORI:  res = a | {16'h0000, word[15:0]};
      default: ok = 1'b0;
   endcase
   if (ok) begin
      if (dst != '0) model_regs[dst] = res;
      e.cyc = issued + lat;
      e.rd  = dst;
      e.val = res;
      pos   = exp_q.size();
      while (pos > 0 && exp_q[pos-1].cyc > e.cyc) pos--;
      exp_q.insert(pos, e);
   end
endfunction

`endif

/* bench/cpu_core_tb.sv */
`timescale 1ns/1ns

module cpu_core_tb;
   import cpu_pkg::*;

   localparam int MULT_STAGES  = 5;
   localparam int RESET_CYCLES = 5;
   localparam int IDLE_CYCLES  = 8;
   localparam int DIRECTED     = 40;   // Upper bound of the directed part
   localparam int RANDOM_COUNT = 400;
   localparam int DRAIN        = MULT_STAGES + 4;
   localparam int TIMEOUT      = RESET_CYCLES + IDLE_CYCLES + DIRECTED + RANDOM_COUNT + DRAIN + 50;

   logic      clk;
   logic      mem_wb_reset;
   logic      instr_valid;
   data_t     instr;
   logic      wb_valid;
   reg_addr_t wb_reg;
   data_t     wb_data;

   int                     cycle = 0;
   int                     value_errors = 0;
   int                     extra_errors = 0;
   int                     missing_errors = 0;
   int                     mult_at [32];   // Drive cycle of the last mult per destination
   logic [MULT_STAGES-2:0] mult_hist;      // Bit i set when a mult was driven i+1 cycles ago

   `include "tb_ref_model.svh"

   cpu_core #(
      .MULT_STAGES (MULT_STAGES)
   ) DUT (
      .clk          (clk),
      .mem_wb_reset (mem_wb_reset),
      .instr_valid  (instr_valid),
      .instr        (instr),
      .wb_valid     (wb_valid),
      .wb_reg       (wb_reg),
      .wb_data      (wb_data)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
      if (got !== exp) begin
         $display("** Error: %s = 0x%0h, expected 0x%0h (cycle %0d)", name, got, exp, cycle);
         value_errors++;
      end
   endtask

   task automatic print_counts();
      $display("Errors: %0d wrong values, %0d unexpected write-backs, %0d missing write-backs",
               value_errors, extra_errors, missing_errors);
   endtask

   // Register still waiting for a mult result
   function automatic logic busy(reg_addr_t r);
      return r != '0 && cycle - mult_at[r] < MULT_STAGES;
   endfunction

   task automatic drive(logic valid, data_t word);
      logic is_m;
      is_m        = valid && word[31:26] == OP_RTYPE && word[5:0] == FN_MULT;
      instr_valid = valid;
      instr       = word;
      mult_hist   = {mult_hist[MULT_STAGES-3:0], is_m};
      if (is_m) mult_at[word[15:11]] = cycle;
      if (valid) predict(word, cycle);
   endtask

   task automatic issue(logic valid, data_t word);
      @(posedge clk);
      #1;
      drive(valid, word);
   endtask

   // Random instruction that becomes a bubble where it would break a stream rule
   task automatic send_random();
      logic [3:0]  kind;
      reg_addr_t   rs;
      reg_addr_t   rt;
      reg_addr_t   rd;
      logic [15:0] imm;
      data_t       word;
      logic        alu;
      logic        ok;
      @(posedge clk);
      #1;
      kind = 4'(next_random(4));
      rs   = reg_addr_t'(next_random(3));  // Few registers give many dependencies
      rt   = reg_addr_t'(next_random(3));
      rd   = reg_addr_t'(next_random(3));
      imm  = 16'(next_random(16));
      alu  = 1'b1;
      case (kind)
         4'd0, 4'd1: word = rtype_word(FN_ADD, rd, rs, rt);
         4'd2:       word = rtype_word(FN_SUB, rd, rs, rt);
         4'd3:       word = rtype_word(FN_AND, rd, rs, rt);
         4'd4:       word = rtype_word(FN_OR, rd, rs, rt);
         4'd5:       word = rtype_word(FN_XOR, rd, rs, rt);
         4'd6:       word = rtype_word(FN_SLT, rd, rs, rt);
         4'd7, 4'd8: begin
            word = rtype_word(FN_MULT, rd, rs, rt);
            alu  = 1'b0;
         end
         4'd9, 4'd12: word = itype_word(OP_ADDI, rt, rs, imm);
         4'd10:       word = itype_word(OP_ANDI, rt, rs, imm);
         4'd11:       word = itype_word(OP_ORI, rt, rs, imm);
         4'd13:       word = itype_word(6'h3f, rt, rs, imm);  // Unknown opcode
         4'd14:       word = rtype_word(6'h3f, rd, rs, rt);   // Unknown funct
         default:     word = '0;
      endcase
      ok = !busy(rs) && !busy(rt) && !busy(rd) && kind != 4'd15;
      if (alu && mult_hist[MULT_STAGES-2]) ok = 1'b0;  // Same write-back slot as a mult
      drive(ok, word);
   endtask

   always @(posedge clk) begin
      cycle++;
      if (cycle > TIMEOUT) begin
         $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
         print_counts();
         $display("Test failures found");
         $finish;
      end
   end

   // Write-back compare at mid-cycle
   always @(negedge clk) begin : compare
      exp_t e;
      if (!mem_wb_reset) begin
         while (exp_q.size() > 0 && exp_q[0].cyc < cycle) begin
            $display("Missing write-back to r%0d, due in cycle %0d", exp_q[0].rd, exp_q[0].cyc);
            missing_errors++;
            void'(exp_q.pop_front());
         end
         if (wb_valid !== 1'b0) begin
            if (exp_q.size() == 0 || exp_q[0].cyc != cycle) begin
               $display("Unexpected write-back to r%0d in cycle %0d", wb_reg, cycle);
               extra_errors++;
            end else begin
               e = exp_q.pop_front();
               check_value("wb_reg", wb_reg, e.rd);
               check_value("wb_data", wb_data, e.val);
            end
         end
      end
   end

   initial begin
      mem_wb_reset = 1'b1;
      instr_valid  = 1'b0;
      instr        = '0;
      lfsr_state   = 32'h43a8_ff2d;
      mult_hist    = '0;
      foreach (mult_at[r]) mult_at[r] = -1000;
      foreach (model_regs[r]) model_regs[r] = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 mem_wb_reset = 1'b0;
      repeat (IDLE_CYCLES) issue(1'b0, '0);

      issue(1'b1, itype_word(OP_ORI, 5'd1, 5'd0, 16'h9234));   // Zero extended
      issue(1'b1, itype_word(OP_ADDI, 5'd2, 5'd0, 16'hfffb));  // Sign extended
      issue(1'b1, itype_word(OP_ANDI, 5'd3, 5'd2, 16'h8f0f));  // Forwarded and zero extended
      issue(1'b1, itype_word(OP_ORI, 5'd4, 5'd2, 16'h8000));   // Write-through
      issue(1'b1, rtype_word(FN_ADD, 5'd5, 5'd4, 5'd3));
      issue(1'b1, rtype_word(FN_SUB, 5'd6, 5'd1, 5'd5));
      issue(1'b1, rtype_word(FN_SLT, 5'd7, 5'd2, 5'd1));
      issue(1'b1, rtype_word(FN_XOR, 5'd0, 5'd6, 5'd2));       // r0 write still shows
      issue(1'b1, rtype_word(FN_OR, 5'd8, 5'd0, 5'd1));        // r0 reads zero
      issue(1'b1, itype_word(6'h3f, 5'd9, 5'd1, 16'h5555));
      issue(1'b1, rtype_word(6'h01, 5'd9, 5'd1, 5'd2));
      issue(1'b1, rtype_word(FN_MULT, 5'd10, 5'd2, 5'd6));     // Two mults in flight
      issue(1'b1, rtype_word(FN_MULT, 5'd11, 5'd1, 5'd1));
      issue(1'b1, rtype_word(FN_AND, 5'd12, 5'd1, 5'd2));
      issue(1'b1, rtype_word(FN_SLT, 5'd13, 5'd6, 5'd2));
      repeat (2) issue(1'b0, '0);                              // These slots collide
      issue(1'b1, rtype_word(FN_ADD, 5'd14, 5'd10, 5'd11));
      repeat (MULT_STAGES + 2) issue(1'b0, '0);

      repeat (RANDOM_COUNT) send_random();
      repeat (DRAIN) issue(1'b0, '0);
      @(posedge clk);

      if (exp_q.size() != 0) begin
         $display("%0d expected write-backs never arrived", exp_q.size());
         missing_errors += exp_q.size();
      end
      print_counts();
      if (value_errors + extra_errors + missing_errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

/* logic/cpu_core.sv */
`timescale 1ns/1ns

module cpu_core #(
   parameter int MULT_STAGES = 5
) (
   input  logic               clk,
   input  logic               mem_wb_reset,
   input  logic               instr_valid,
   input  cpu_pkg::data_t     instr,
   output logic               wb_valid,
   output cpu_pkg::reg_addr_t wb_reg,
   output cpu_pkg::data_t     wb_data
);
   import cpu_pkg::*;

   logic      alu_valid;
   reg_addr_t alu_rd;
   data_t     alu_result;
   logic      mul_valid;
   reg_addr_t mul_rd;
   data_t     mul_result;

   dec_exec_if dx ();

   // Write-back also feeds the register file write port
   decode_stage u_decode (
      .clk          (clk),
      .mem_wb_reset (mem_wb_reset),
      .instr_valid  (instr_valid),
      .instr        (instr),
      .wr_en        (wb_valid),
      .wr_reg       (wb_reg),
      .wr_data      (wb_data),
      .dx           (dx.decode)
   );

   exec_stage u_exec (
      .dx         (dx.execute),
      .wb_valid   (wb_valid),
      .wb_reg     (wb_reg),
      .wb_data    (wb_data),
      .alu_valid  (alu_valid),
      .alu_rd     (alu_rd),
      .alu_result (alu_result)
   );

   mult_pipe #(
      .MULT_STAGES (MULT_STAGES)
   ) u_mult (
      .clk          (clk),
      .mem_wb_reset (mem_wb_reset),
      .dx           (dx.mult),
      .wb_valid     (wb_valid),
      .wb_reg       (wb_reg),
      .wb_data      (wb_data),
      .mul_valid    (mul_valid),
      .mul_rd       (mul_rd),
      .mul_result   (mul_result)
   );

   result_stage u_result (
      .clk          (clk),
      .mem_wb_reset (mem_wb_reset),
      .alu_valid    (alu_valid),
      .alu_rd       (alu_rd),
      .alu_result   (alu_result),
      .mul_valid    (mul_valid),
      .mul_rd       (mul_rd),
      .mul_result   (mul_result),
      .wb_valid     (wb_valid),
      .wb_reg       (wb_reg),
      .wb_data      (wb_data)
   );

endmodule

/* logic/result_stage.sv */
`timescale 1ns/1ns

module result_stage (
   input  logic               clk,
   input  logic               mem_wb_reset,
   input  logic               alu_valid,
   input  cpu_pkg::reg_addr_t alu_rd,
   input  cpu_pkg::data_t     alu_result,
   input  logic               mul_valid,
   input  cpu_pkg::reg_addr_t mul_rd,
   input  cpu_pkg::data_t     mul_result,
   output logic               wb_valid,
   output cpu_pkg::reg_addr_t wb_reg,
   output cpu_pkg::data_t     wb_data
);
   import cpu_pkg::*;

   logic      alu_valid_q;
   reg_addr_t alu_rd_q;
   data_t     alu_result_q;

   always_ff @(posedge clk) begin
      if (mem_wb_reset) begin
         alu_valid_q  <= 1'b0;
         alu_rd_q     <= '0;
         alu_result_q <= '0;
      end else begin
         alu_valid_q  <= alu_valid;
         alu_rd_q     <= alu_rd;
         alu_result_q <= alu_result;
      end
   end

   // ALU wins a collision, the multiply result is dropped
   assign wb_valid = alu_valid_q | mul_valid;
   assign wb_reg   = alu_valid_q ? alu_rd_q : mul_rd;
   assign wb_data  = alu_valid_q ? alu_result_q : mul_result;

endmodule

/* logic/mult_pipe.sv */
`timescale 1ns/1ns

module mult_pipe #(
   parameter int MULT_STAGES = 5
) (
   input  logic               clk,
   input  logic               mem_wb_reset,
   dec_exec_if.mult           dx,
   input  logic               wb_valid,
   input  cpu_pkg::reg_addr_t wb_reg,
   input  cpu_pkg::data_t     wb_data,
   output logic               mul_valid,
   output cpu_pkg::reg_addr_t mul_rd,
   output cpu_pkg::data_t     mul_result
);
   import cpu_pkg::*;

   logic [MULT_STAGES-1:0] valid_q;
   reg_addr_t              rd_q   [MULT_STAGES];
   data_t                  prod_q [MULT_STAGES];
   data_t                  op_a;
   data_t                  op_b;

   // Same forwarding rule as the ALU path
   assign op_a = (wb_valid && wb_reg != '0 && wb_reg == dx.rs_addr) ? wb_data : dx.rs_val;
   assign op_b = (wb_valid && wb_reg != '0 && wb_reg == dx.rt_addr) ? wb_data : dx.rt_val;

   always_ff @(posedge clk) begin
      if (mem_wb_reset) begin
         valid_q <= '0;
      end else begin
         valid_q[0] <= dx.valid & dx.is_mult;
         for (int s = 1; s < MULT_STAGES; s++) begin
            valid_q[s] <= valid_q[s-1];
         end
      end
   end

   // Product formed in step 1, later steps only carry it
   always_ff @(posedge clk) begin
      prod_q[0] <= op_a * op_b;  // Low 32 bits kept
      rd_q[0]   <= dx.rd;
      for (int s = 1; s < MULT_STAGES; s++) begin
         prod_q[s] <= prod_q[s-1];
         rd_q[s]   <= rd_q[s-1];
      end
   end

   assign mul_valid  = valid_q[MULT_STAGES-1];
   assign mul_rd     = rd_q[MULT_STAGES-1];
   assign mul_result = prod_q[MULT_STAGES-1];

endmodule

/* logic/exec_stage.sv */
`timescale 1ns/1ns

module exec_stage (
   dec_exec_if.execute        dx,
   input  logic               wb_valid,
   input  cpu_pkg::reg_addr_t wb_reg,
   input  cpu_pkg::data_t     wb_data,
   output logic               alu_valid,
   output cpu_pkg::reg_addr_t alu_rd,
   output cpu_pkg::data_t     alu_result
);
   import cpu_pkg::*;

   logic  fwd_a;
   logic  fwd_b;
   data_t op_a;
   data_t rt_fwd;
   data_t op_b;

   // Result from the previous instruction, not yet in the register file
   assign fwd_a = wb_valid && wb_reg != '0 && wb_reg == dx.rs_addr;
   assign fwd_b = wb_valid && wb_reg != '0 && wb_reg == dx.rt_addr;

   assign op_a   = fwd_a ? wb_data : dx.rs_val;
   assign rt_fwd = fwd_b ? wb_data : dx.rt_val;
   assign op_b   = dx.use_imm ? dx.imm_val : rt_fwd;

   always_comb begin
      case (dx.alu_op)
         ALU_ADD: alu_result = op_a + op_b;
         ALU_SUB: alu_result = op_a - op_b;
         ALU_AND: alu_result = op_a & op_b;
         ALU_OR:  alu_result = op_a | op_b;
         ALU_XOR: alu_result = op_a ^ op_b;
         ALU_SLT: begin
            // Signed compare
            alu_result = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
         end
         default: alu_result = '0;
      endcase
   end

   assign alu_valid = dx.valid & ~dx.is_mult;  // Multiplies go the other way
   assign alu_rd    = dx.rd;

endmodule

/* logic/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage (
   input  logic               clk,
   input  logic               mem_wb_reset,
   input  logic               instr_valid,
   input  cpu_pkg::instr_u    instr,
   input  logic               wr_en,
   input  cpu_pkg::reg_addr_t wr_reg,
   input  cpu_pkg::data_t     wr_data,
   dec_exec_if.decode         dx
);
   import cpu_pkg::*;

   data_t     rs_data;      // Register file read ports
   data_t     rt_data;
   logic      dec_ok;       // Known opcode and function
   logic      dec_mult;
   alu_op_e   dec_op;
   reg_addr_t dec_rd;
   data_t     dec_imm;
   logic      dec_use_imm;

   // rs and rt sit at the same bits in both layouts
   reg_file u_reg_file (
      .clk          (clk),
      .mem_wb_reset (mem_wb_reset),
      .rd_addr_a    (instr.r.rs),
      .rd_addr_b    (instr.r.rt),
      .wr_en        (wr_en),
      .wr_reg       (wr_reg),
      .wr_data      (wr_data),
      .rd_data_a    (rs_data),
      .rd_data_b    (rt_data)
   );

   always_comb begin
      dec_ok      = 1'b0;
      dec_mult    = 1'b0;
      dec_op      = ALU_ADD;
      dec_rd      = instr.r.rd;
      dec_imm     = {{16{instr.i.imm[15]}}, instr.i.imm};  // Sign extended by default
      dec_use_imm = 1'b0;
      case (instr.r.opcode)
         OP_RTYPE: begin
            dec_ok = 1'b1;
            case (instr.r.funct)
               FN_ADD:  dec_op = ALU_ADD;
               FN_SUB:  dec_op = ALU_SUB;
               FN_AND:  dec_op = ALU_AND;
               FN_OR:   dec_op = ALU_OR;
               FN_XOR:  dec_op = ALU_XOR;
               FN_SLT:  dec_op = ALU_SLT;
               FN_MULT: dec_mult = 1'b1;
               default: dec_ok = 1'b0;  // Unknown funct is dropped
            endcase
         end
         OP_ADDI, OP_ANDI, OP_ORI: begin
            dec_ok      = 1'b1;
            dec_rd      = instr.i.rt;
            dec_use_imm = 1'b1;
            if (instr.i.opcode == OP_ANDI) begin
               dec_op  = ALU_AND;
               dec_imm = {16'h0000, instr.i.imm};
            end else if (instr.i.opcode == OP_ORI) begin
               dec_op  = ALU_OR;
               dec_imm = {16'h0000, instr.i.imm};
            end
         end
         default: dec_ok = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (mem_wb_reset) dx.valid <= 1'b0;
      else              dx.valid <= instr_valid & dec_ok;
   end

   // Decoded payload, qualified by dx.valid
   always_ff @(posedge clk) begin
      dx.is_mult <= dec_mult;
      dx.alu_op  <= dec_op;
      dx.rd      <= dec_rd;
      dx.rs_addr <= instr.r.rs;
      dx.rt_addr <= instr.r.rt;
      dx.rs_val  <= rs_data;
      dx.rt_val  <= rt_data;
      dx.imm_val <= dec_imm;
      dx.use_imm <= dec_use_imm;
   end

endmodule

/* logic/reg_file.sv */
`timescale 1ns/1ns

module reg_file (
   input  logic               clk,
   input  logic               mem_wb_reset,
   input  cpu_pkg::reg_addr_t rd_addr_a,
   input  cpu_pkg::reg_addr_t rd_addr_b,
   input  logic               wr_en,
   input  cpu_pkg::reg_addr_t wr_reg,
   input  cpu_pkg::data_t     wr_data,
   output cpu_pkg::data_t     rd_data_a,
   output cpu_pkg::data_t     rd_data_b
);
   import cpu_pkg::*;

   data_t regs [2**REG_ADDR_W];

   always_ff @(posedge clk) begin
      if (mem_wb_reset) begin
         for (int n = 0; n < 2**REG_ADDR_W; n++) begin
            regs[n] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_reg] <= wr_data;
      end
   end

   // Write-through so a same-cycle read sees the new value
   always_comb begin
      if (rd_addr_a == '0)                  rd_data_a = '0;
      else if (wr_en && wr_reg == rd_addr_a) rd_data_a = wr_data;
      else                                   rd_data_a = regs[rd_addr_a];

      if (rd_addr_b == '0)                  rd_data_b = '0;
      else if (wr_en && wr_reg == rd_addr_b) rd_data_b = wr_data;
      else                                   rd_data_b = regs[rd_addr_b];
   end

endmodule

/* logic/dec_exec_if.sv */
`timescale 1ns/1ns

interface dec_exec_if;
   import cpu_pkg::*;

   logic      valid;    // One cycle per accepted instruction
   logic      is_mult;  // Routed to the multiply pipeline
   alu_op_e   alu_op;
   reg_addr_t rd;
   reg_addr_t rs_addr;
   reg_addr_t rt_addr;
   data_t     rs_val;
   data_t     rt_val;
   data_t     imm_val;  // Already extended
   logic      use_imm;

   modport decode (
      output valid, is_mult, alu_op, rd, rs_addr, rt_addr, rs_val, rt_val, imm_val, use_imm
   );
   modport execute (
      input valid, is_mult, alu_op, rd, rs_addr, rt_addr, rs_val, rt_val, imm_val, use_imm
   );
   modport mult (
      input valid, is_mult, rd, rs_addr, rt_addr, rs_val, rt_val
   );

endinterface

/* logic/cpu_pkg.sv */
package cpu_pkg;

   localparam int DATA_W     = 32;
   localparam int REG_ADDR_W = 5;

   typedef logic [DATA_W-1:0]     data_t;
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;

   // Primary opcodes
   localparam logic [5:0] OP_RTYPE = 6'h00;
   localparam logic [5:0] OP_ADDI  = 6'h08;
   localparam logic [5:0] OP_ANDI  = 6'h0c;
   localparam logic [5:0] OP_ORI   = 6'h0d;

   // R-type function field
   localparam logic [5:0] FN_ADD  = 6'h20;
   localparam logic [5:0] FN_SUB  = 6'h22;
   localparam logic [5:0] FN_AND  = 6'h24;
   localparam logic [5:0] FN_OR   = 6'h25;
   localparam logic [5:0] FN_XOR  = 6'h26;
   localparam logic [5:0] FN_SLT  = 6'h2a;
   localparam logic [5:0] FN_MULT = 6'h18;

   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_XOR = 3'd4,
      ALU_SLT = 3'd5
   } alu_op_e;

   typedef struct packed {
      logic [5:0] opcode;
      reg_addr_t  rs;
      reg_addr_t  rt;
      reg_addr_t  rd;
      logic [4:0] shamt;  // Not used by this core
      logic [5:0] funct;
   } r_type_t;

   typedef struct packed {
      logic [5:0]  opcode;
      reg_addr_t   rs;
      reg_addr_t   rt;    // Destination for I-type
      logic [15:0] imm;
   } i_type_t;

   // Same instruction word, two field layouts
   typedef union packed {
      r_type_t r;
      i_type_t i;
   } instr_u;

endpackage
